// ==== sim/dp_stim.txt ====
// test coef_base coef_stride psum_base psum_stride mask spot_idx spot_lane0
// values are (base + stride * n) mod modulus, n = poly * 128 + index, all hex
// 1: reset state and plain pass
1 10 3 100 5 0 25 238
// 2: bases near the modulus, sums wrap
2 3FFFFFBFC1 1 3FFFFFBF81 1 0 10 3FFFFFBF61
// 3: masked reload of the test 1 page
3 2000 7 0 11 1 5A 2870
// 4: load and swap request during a running pass
4 0 1 3FFFFFC000 0 0 3 2
// 5: second start pulse while busy
5 1234 9 777 2 0 7F 1F20

// ==== flist.f ====
common/dp_pkg.sv
common/dp_rd_if.sv
buffer/dp_pp_buffer.sv
madd/dp_madd_pipe.sv
src/dp_ctrl.sv
src/dp_top.sv
sim/dp_checker.sv
sim/dp_assert.sv
sim/tb_dp_top.sv

// ==== sim/tb_dp_top.sv ====
// testbench for dp_top with per-test generator words from sim/dp_stim.txt
// models the host loader, the page contents and the upstream psum memory
`default_nettype none

module tb_dp_top
    import dp_pkg::*;
();

    localparam int NUM_TESTS = 5;
    localparam int STIM_W    = 8;               // words per stim line
    localparam int NUM_ROW   = 1 << ROW_ADDR_W;
    localparam int T_LIMIT   = 400;             // cycles per wait

    logic                         clk;
    logic                         i_reset;
    logic [NUM_POLY*NUM_BANK-1:0] i_axi_we;
    logic [ROW_ADDR_W-1:0]        i_axi_wraddr;
    bank_row_t                    i_axi_data;
    logic                         i_axi_done;
    logic                         i_madd_start;
    coef_vec_t                    i_madd_data;
    logic                         o_madd_done;
    logic                         o_madd_we;
    logic [COEF_ADDR_W-1:0]       o_madd_wraddr;
    coef_vec_t                    o_madd_data;
    logic [COEF_ADDR_W-1:0]       o_madd_rdaddr;

    logic [63:0] stim_mem [NUM_TESTS*STIM_W];
    coef_t       page_mdl [2][NUM_POLY][COEFS_PER_POLY];   // both pages by flat index
    coef_vec_t   psum_mem [COEFS_PER_POLY];                // by bank-major address
    bit          page_sel;                                 // compute page model
    bit          timed_out;
    bit          stim_bad;
    int          chk_err;

    dp_top #(.MADD_PIPE_STAGES(4)) dut0 (
        .clk           (clk),
        .i_reset       (i_reset),
        .i_axi_we      (i_axi_we),
        .i_axi_wraddr  (i_axi_wraddr),
        .i_axi_data    (i_axi_data),
        .i_axi_done    (i_axi_done),
        .i_madd_start  (i_madd_start),
        .o_madd_done   (o_madd_done),
        .o_madd_we     (o_madd_we),
        .o_madd_wraddr (o_madd_wraddr),
        .o_madd_data   (o_madd_data),
        .o_madd_rdaddr (o_madd_rdaddr),
        .i_madd_data   (i_madd_data)
    );

    dp_checker chk0 (
        .clk           (clk),
        .i_reset       (i_reset),
        .i_madd_we     (o_madd_we),
        .i_madd_wraddr (o_madd_wraddr),
        .i_madd_data   (o_madd_data),
        .i_madd_done   (o_madd_done),
        .o_err_cnt     (chk_err)
    );

    initial begin : clk_gen
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // upstream memory with one cycle read latency
    initial begin : psum_model
        logic [COEF_ADDR_W-1:0] addr_q;
        addr_q      = '0;
        i_madd_data = '0;
        forever begin
            @(negedge clk);
            i_madd_data = psum_mem[addr_q];
            addr_q      = o_madd_rdaddr;   // issued this cycle
        end
    end

    //////////////////////////////////////////////////////////////////////
    // models
    //////////////////////////////////////////////////////////////////////
    function automatic coef_t gen_val(logic [63:0] base, logic [63:0] stride, int n);
        logic [63:0] acc;
        acc = (base + stride * 64'(n)) % 64'(DP_MODULUS);
        return acc[COE_WIDTH-1:0];
    endfunction

    function automatic coef_t add_mod(coef_t a, coef_t b);
        logic [63:0] s;
        s = (64'(a) + 64'(b)) % 64'(DP_MODULUS);
        return s[COE_WIDTH-1:0];
    endfunction

    function automatic int bank_major(int idx);
        return (idx % NUM_BANK) * NUM_ROW + idx / NUM_BANK;   // bank above row
    endfunction

    task automatic load_psum(input int t);
        for (int i = 0; i < COEFS_PER_POLY; i++) begin
            for (int p = 0; p < NUM_POLY; p++) begin
                psum_mem[bank_major(i)][p] = gen_val(stim_mem[t*STIM_W + 3],
                                                     stim_mem[t*STIM_W + 4],
                                                     p*COEFS_PER_POLY + i);
            end
        end
    endtask

    // one poly row per cycle into the fill page
    task automatic load_page(input int t);
        logic [NUM_BANK-1:0] lane_en;
        int                  spot;
        int                  idx;
        spot = int'(stim_mem[t*STIM_W + 6]);
        for (int p = 0; p < NUM_POLY; p++) begin
            for (int r = 0; r < NUM_ROW; r++) begin
                if (stim_mem[t*STIM_W + 5][0]) begin
                    lane_en = NUM_BANK'($urandom);
                end else begin
                    lane_en = '1;
                end
                if (p == 0 && r == spot / NUM_BANK) begin
                    lane_en[spot % NUM_BANK] = 1'b1;   // spot lane always fresh
                end
                i_axi_wraddr = r[ROW_ADDR_W-1:0];
                i_axi_we     = '0;
                for (int b = 0; b < NUM_BANK; b++) begin
                    idx           = r*NUM_BANK + b;
                    i_axi_data[b] = gen_val(stim_mem[t*STIM_W + 1],
                                            stim_mem[t*STIM_W + 2],
                                            p*COEFS_PER_POLY + idx);
                    i_axi_we[p*NUM_BANK + b] = lane_en[b];
                    if (lane_en[b]) begin
                        page_mdl[!page_sel][p][idx] = i_axi_data[b];
                    end
                end
                @(negedge clk);
            end
        end
        i_axi_we = '0;
    endtask

    task automatic launch_pass(input int t, input bit spot_en);
        coef_vec_t exp_vec;
        for (int i = 0; i < COEFS_PER_POLY; i++) begin
            for (int p = 0; p < NUM_POLY; p++) begin
                exp_vec[p] = add_mod(page_mdl[page_sel][p][i], psum_mem[bank_major(i)][p]);
            end
            chk0.set_expect(i, exp_vec);
        end
        chk0.arm_pass(spot_en, int'(stim_mem[t*STIM_W + 6]),
                      stim_mem[t*STIM_W + 7][COE_WIDTH-1:0]);
        i_madd_start = 1'b1;
        @(negedge clk);
        i_madd_start = 1'b0;
    endtask

    task automatic finish_pass();
        int n;
        n = 0;
        while (o_madd_done !== 1'b1 && n < T_LIMIT && !timed_out) begin
            @(negedge clk);
            n++;
        end
        if (o_madd_done !== 1'b1 && !timed_out) begin
            timed_out = 1'b1;
            $display("timeout, o_madd_done did not rise within %0d cycles", T_LIMIT);
        end
        repeat (8) @(negedge clk);   // stray writes would show here
        chk0.close_pass();
    endtask

    task automatic run_test(input int t);
        int num;
        num = int'(stim_mem[t*STIM_W]);
        chk0.begin_test(num);
        if (num == 1) begin
            chk0.check_idle();
        end
        load_psum(t);
        if (num == 4) begin
            launch_pass(t, 1'b0);   // runs on the old page
            load_page(t);
            i_axi_done = 1'b1;      // swap held off until done
            finish_pass();
            i_axi_done = 1'b0;
            page_sel   = ~page_sel;
            launch_pass(t, 1'b1);
            finish_pass();
        end else begin
            load_page(t);
            i_axi_done = 1'b1;
            @(negedge clk);
            i_axi_done = 1'b0;
            page_sel   = ~page_sel;
            launch_pass(t, 1'b1);
            if (num == 5) begin
                repeat (20) @(negedge clk);
                i_madd_start = 1'b1;   // busy so it is ignored
                @(negedge clk);
                i_madd_start = 1'b0;
            end
            finish_pass();
        end
        chk0.end_test();
    endtask

    //////////////////////////////////////////////////////////////////////
    // sequence
    //////////////////////////////////////////////////////////////////////
    initial begin : main_seq
        void'($urandom(32'h5d30_e72c));
        i_reset      = 1'b1;
        i_axi_we     = '0;
        i_axi_wraddr = '0;
        i_axi_data   = '0;
        i_axi_done   = 1'b0;
        i_madd_start = 1'b0;
        page_sel     = 1'b0;
        timed_out    = 1'b0;
        for (int i = 0; i < COEFS_PER_POLY; i++) begin
            psum_mem[i] = '0;
        end
        $readmemh("sim/dp_stim.txt", stim_mem);
        stim_bad = $isunknown(stim_mem[NUM_TESTS*STIM_W - 1]);
        if (stim_bad) begin
            $display("stim file sim/dp_stim.txt missing or short");
        end
        repeat (16) @(negedge clk);
        i_reset = 1'b0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            if (!timed_out && !stim_bad) begin
                run_test(t);
            end
        end
        chk0.report_counts();
        if (timed_out || stim_bad || chk_err != 0 || dut0.assert0.n_fail != 0) begin
            $display("sim failed");
        end else begin
            $display("sim passed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/dp_assert.sv ====
// protocol assertions on the dp_top done and write outputs
// attached to dp_top by the bind below
`default_nettype none

module dp_assert
    import dp_pkg::*;
(
    input wire            clk,
    input wire            i_reset,
    input wire            i_we,
    input wire            i_done,
    input wire coef_vec_t i_data
);

    int unsigned n_fail = 0;    // failed assertion count

    // done means nothing left to write
    a_we_done : assert property (@(posedge clk) disable iff (i_reset) !(i_we && i_done))
        else begin
            n_fail++;
            $error("o_madd_we high while o_madd_done high");
        end

    // reduced lanes stay below the modulus
    for (genvar p = 0; p < NUM_POLY; p++) begin : g_lane
        a_lane_mod : assert property (@(posedge clk) disable iff (i_reset)
                                      i_we |-> (i_data[p] < DP_MODULUS))
            else begin
                n_fail++;
                $error("o_madd_data lane %0d not below modulus", p);
            end
    end

    a_rst_idle : assert property (@(posedge clk) $fell(i_reset) |-> (!i_done && !i_we))
        else begin
            n_fail++;
            $error("o_madd_done or o_madd_we high after reset");
        end

endmodule

bind dp_top dp_assert assert0 (
    .clk     (clk),
    .i_reset (i_reset),
    .i_we    (o_madd_we),
    .i_done  (o_madd_done),
    .i_data  (o_madd_data)
);

`default_nettype wire

// ==== sim/dp_checker.sv ====
// downstream write monitor for the dot-product testbench
// holds the expected lanes of one pass, counts writes, done rises and errors
`default_nettype none

module dp_checker
    import dp_pkg::*;
(
    input  wire                    clk,
    input  wire                    i_reset,
    input  wire                    i_madd_we,
    input  wire [COEF_ADDR_W-1:0]  i_madd_wraddr,   // bank-major
    input  wire coef_vec_t         i_madd_data,
    input  wire                    i_madd_done,
    output int                     o_err_cnt
);

    coef_vec_t exp_mem [COEFS_PER_POLY];   // per index, filled by the testbench
    bit        seen    [COEFS_PER_POLY];
    bit        armed;                      // a pass is expected to write
    bit        spot_en;
    int        spot_idx;
    coef_t     spot_val;                   // lane 0 value from the stim file
    int        n_wr;
    int        n_rise;
    int        test_num;
    int        test_err;
    int        err_total = 0;
    int        n_tests   = 0;
    int        n_bad     = 0;
    logic      done_q    = 1'b0;

    assign o_err_cnt = err_total;

    task automatic note_error();
        test_err++;
        err_total++;
    endtask

    task automatic set_expect(input int idx, input coef_vec_t v);
        exp_mem[idx] = v;
    endtask

    task automatic begin_test(input int num);
        test_num = num;
        test_err = 0;
    endtask

    task automatic check_idle();
        if (i_madd_done !== 1'b0) begin
            $display("error at %0t: o_madd_done got %b expected 0", $time, i_madd_done);
            note_error();
        end
        if (i_madd_we !== 1'b0) begin
            $display("error at %0t: o_madd_we got %b expected 0", $time, i_madd_we);
            note_error();
        end
    endtask

    task automatic arm_pass(input bit en, input int idx, input coef_t val);
        for (int i = 0; i < COEFS_PER_POLY; i++) begin
            seen[i] = 1'b0;
        end
        spot_en  = en;
        spot_idx = idx;
        spot_val = val;
        n_wr     = 0;
        n_rise   = 0;
        armed    = 1'b1;
    endtask

    task automatic close_pass();
        armed = 1'b0;
        if (n_wr != COEFS_PER_POLY) begin
            $display("test %0d: pass wrote %0d indices, not %0d", test_num, n_wr, COEFS_PER_POLY);
            note_error();
        end
        if (n_rise != 1) begin
            $display("test %0d: o_madd_done rose %0d times in one pass", test_num, n_rise);
            note_error();
        end
    endtask

    task automatic end_test();
        n_tests++;
        if (test_err != 0) begin
            n_bad++;
            $display("test %0d: %0d errors", test_num, test_err);
        end else begin
            $display("test %0d: ok", test_num);
        end
    endtask

    task automatic report_counts();
        $display("tests run %0d, clean %0d, with errors %0d, total errors %0d",
                 n_tests, n_tests - n_bad, n_bad, err_total);
    endtask

    //////////////////////////////////////////////////////////////////////
    // write compare
    //////////////////////////////////////////////////////////////////////
    task automatic check_write();
        int idx;
        // back from bank-major to flat index
        idx = int'(i_madd_wraddr[ROW_ADDR_W-1:0]) * NUM_BANK
            + int'(i_madd_wraddr[COEF_ADDR_W-1:ROW_ADDR_W]);
        if (!armed) begin
            $display("write to address %0h while no pass is running", i_madd_wraddr);
            note_error();
        end else begin
            if (seen[idx]) begin
                $display("test %0d: index %0d written twice", test_num, idx);
                note_error();
            end else begin
                n_wr++;
            end
            seen[idx] = 1'b1;
            for (int p = 0; p < NUM_POLY; p++) begin
                if (i_madd_data[p] !== exp_mem[idx][p]) begin
                    $display("error at %0t: o_madd_data[%0d] idx %0d got %h expected %h",
                             $time, p, idx, i_madd_data[p], exp_mem[idx][p]);
                    note_error();
                end
            end
            if (spot_en && idx == spot_idx && i_madd_data[0] !== spot_val) begin
                $display("error at %0t: o_madd_data[0] spot idx %0d got %h expected %h",
                         $time, idx, i_madd_data[0], spot_val);
                note_error();
            end
        end
    endtask

    // outputs are registered, so mid-cycle is stable
    always @(negedge clk) begin : watch
        if (!i_reset) begin
            if (i_madd_done === 1'b1 && done_q !== 1'b1) begin
                n_rise++;
            end
            done_q = i_madd_done;
            if (i_madd_we === 1'b1) begin
                check_write();
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/dp_top.sv ====
// dot-product datapath top, one polynomial vector
// host loads through the wide write port, a pass adds buffered coefs to
// upstream partial sums and writes the downstream memory
`default_nettype none

module dp_top
    import dp_pkg::*;
#(
    parameter int MADD_PIPE_STAGES = 4    // add result register stages
)(
    input  wire                              clk,
    input  wire                              i_reset,
    // host load
    input  wire [NUM_POLY*NUM_BANK-1:0]      i_axi_we,
    input  wire [ROW_ADDR_W-1:0]             i_axi_wraddr,
    input  wire bank_row_t                   i_axi_data,
    input  wire                              i_axi_done,
    // pass control
    input  wire                              i_madd_start,
    output logic                             o_madd_done,
    // downstream memory write
    output logic                             o_madd_we,
    output logic [COEF_ADDR_W-1:0]           o_madd_wraddr,   // bank-major
    output coef_vec_t                        o_madd_data,
    // upstream memory read
    output logic [COEF_ADDR_W-1:0]           o_madd_rdaddr,   // bank-major
    input  wire coef_vec_t                   i_madd_data
);

    dp_rd_if rd_if ();       // ctrl -> buffer -> lanes

    logic       pipe_empty;
    coef_addr_u madd_wraddr;    // row/bank view from the lanes

    //////////////////////////////////////////////////////////////////////
    // blocks
    //////////////////////////////////////////////////////////////////////
    dp_ctrl ctrl0 (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_axi_done   (i_axi_done),
        .i_madd_start (i_madd_start),
        .i_pipe_empty (pipe_empty),
        .o_madd_done  (o_madd_done),
        .rd           (rd_if.ctrl)
    );

    dp_pp_buffer pp0 (
        .clk          (clk),
        .i_axi_we     (i_axi_we),
        .i_axi_wraddr (i_axi_wraddr),
        .i_axi_data   (i_axi_data),
        .rd           (rd_if.store)
    );

    dp_madd_pipe #(
        .MADD_PIPE_STAGES (MADD_PIPE_STAGES)
    ) madd0 (
        .clk      (clk),
        .i_reset  (i_reset),
        .rd       (rd_if.lane),
        .i_psum   (i_madd_data),
        .o_we     (o_madd_we),
        .o_wraddr (madd_wraddr),
        .o_data   (o_madd_data),
        .o_empty  (pipe_empty)
    );

    // external memories use bank above row
    assign o_madd_rdaddr = {rd_if.rd_addr.loc.bank, rd_if.rd_addr.loc.row};
    assign o_madd_wraddr = {madd_wraddr.loc.bank, madd_wraddr.loc.row};

endmodule

`default_nettype wire

// ==== src/dp_ctrl.sv ====
// page swap and multiply-add pass sequencing
// start pulse kicks off one pass over every coefficient index, done level
// reports the pass finished and gates the page swap
`default_nettype none

module dp_ctrl
    import dp_pkg::*;
(
    input  wire      clk,
    input  wire      i_reset,
    input  wire      i_axi_done,     // host finished loading fill page
    input  wire      i_madd_start,   // one-cycle pulse
    input  wire      i_pipe_empty,
    output logic     o_madd_done,
    dp_rd_if.ctrl    rd
);

    // fsm encoding
    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_ISSUE = 2'd1;    // one index per cycle
    localparam logic [1:0] ST_DRAIN = 2'd2;    // wait for lanes to empty

    logic [1:0]             state;
    logic [COEF_ADDR_W-1:0] idx_cnt;           // next index to issue
    logic                   last_idx;
    logic                   swap_cond;
    logic                   swap_cond_q;       // history for edge detect
    logic                   page_q;

    //////////////////////////////////////////////////////////////////////
    // page swap
    //////////////////////////////////////////////////////////////////////
    // loading done and no pass running
    assign swap_cond = i_axi_done && (state == ST_IDLE);

    always_ff @(posedge clk) begin : swap_ff
        if (i_reset) begin
            swap_cond_q <= 1'b0;
            page_q      <= 1'b0;
        end else begin
            swap_cond_q <= swap_cond;
            if (swap_cond && !swap_cond_q) begin
                page_q <= ~page_q;   // rising edge only
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // pass fsm
    //////////////////////////////////////////////////////////////////////
    assign last_idx = (idx_cnt == COEF_ADDR_W'(COEFS_PER_POLY - 1));

    always_ff @(posedge clk) begin : pass_fsm
        if (i_reset) begin
            state       <= ST_IDLE;
            idx_cnt     <= '0;
            o_madd_done <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (i_madd_start) begin       // starts while busy never get here
                        state       <= ST_ISSUE;
                        idx_cnt     <= '0;
                        o_madd_done <= 1'b0;      // falls at accept edge
                    end
                end
                ST_ISSUE: begin
                    idx_cnt <= idx_cnt + 1'b1;
                    if (last_idx) begin
                        state <= ST_DRAIN;
                    end
                end
                ST_DRAIN: begin
                    // pipe empty means last write is on the bus now
                    if (i_pipe_empty) begin
                        state       <= ST_IDLE;
                        o_madd_done <= 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // read issue toward buffer and lanes
    assign rd.page  = page_q;
    assign rd.rd_en = (state == ST_ISSUE);

    always_comb begin : addr_drv
        rd.rd_addr     = '0;
        rd.rd_addr.idx = idx_cnt;    // flat view, buffer splits it
    end

endmodule

`default_nettype wire

// ==== madd/dp_madd_pipe.sv ====
// modular add lanes per poly plus downstream write generation
// valid and address follow the read stream until the result leaves the
// last register stage
`default_nettype none

module dp_madd_pipe
    import dp_pkg::*;
#(
    parameter int MADD_PIPE_STAGES = 4     // at least one register stage after the add
)(
    input  wire              clk,
    input  wire              i_reset,
    dp_rd_if.lane            rd,
    input  wire coef_vec_t   i_psum,       // upstream partial sums
    output logic             o_we,         // downstream write strobe
    output coef_addr_u       o_wraddr,
    output coef_vec_t        o_data,
    output logic             o_empty       // nothing left to write after this cycle
);

    // buffer read takes one cycle too so both sides line up here
    localparam int ALIGN = PSUM_RD_LATENCY;
    localparam int DEPTH = ALIGN + MADD_PIPE_STAGES;

    logic [DEPTH:1] vld;                            // vld[k] is rd_en k cycles ago
    coef_addr_u     addr_sr [1:DEPTH];              // address rides along
    coef_vec_t      dat_sr  [1:MADD_PIPE_STAGES];   // result stages
    coef_vec_t      sum_mod;                        // reduced sums

    //////////////////////////////////////////////////////////////////////
    // lane adders
    //////////////////////////////////////////////////////////////////////
    always_comb begin : lane_add
        logic [COE_WIDTH:0] raw;    // one extra bit for the carry
        for (int p = 0; p < NUM_POLY; p++) begin
            raw = {1'b0, rd.rd_data[p]} + {1'b0, i_psum[p]};
            // both inputs below modulus so one subtract is enough
            if (raw >= {1'b0, DP_MODULUS}) begin
                raw = raw - {1'b0, DP_MODULUS};
            end
            sum_mod[p] = raw[COE_WIDTH-1:0];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // control shift chain
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin : vld_chain
        if (i_reset) begin
            vld <= '0;
        end else begin
            vld <= {vld[DEPTH-1:1], rd.rd_en};
        end
    end

    // address and sums ride along with valid
    always_ff @(posedge clk) begin : payload_chain
        addr_sr[1] <= rd.rd_addr;
        for (int k = 2; k <= DEPTH; k++) begin
            addr_sr[k] <= addr_sr[k-1];
        end
        dat_sr[1] <= sum_mod;          // data meets vld[ALIGN] here
        for (int k = 2; k <= MADD_PIPE_STAGES; k++) begin
            dat_sr[k] <= dat_sr[k-1];
        end
    end

    // outputs straight from the last stage
    assign o_we     = vld[DEPTH];
    assign o_wraddr = addr_sr[DEPTH];
    assign o_data   = dat_sr[MADD_PIPE_STAGES];

    // last stage retires this cycle so it does not count
    assign o_empty  = ~|vld[DEPTH-1:1];

endmodule

`default_nettype wire

// ==== buffer/dp_pp_buffer.sv ====
// two-page banked coefficient store
// host fills the page not used for compute, compute side reads one
// coefficient index per cycle for every poly
`default_nettype none

module dp_pp_buffer
    import dp_pkg::*;
(
    input  wire                              clk,
    // host write port
    input  wire [NUM_POLY*NUM_BANK-1:0]      i_axi_we,      // bit poly*8 + bank
    input  wire [ROW_ADDR_W-1:0]             i_axi_wraddr,  // one row for all lanes
    input  wire bank_row_t                   i_axi_data,    // lane per bank
    // compute read port
    dp_rd_if.store                           rd
);

    localparam int NUM_ROW = 1 << ROW_ADDR_W;

    //////////////////////////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////////////////////////
    // page x poly x bank x row
    coef_t mem [2][NUM_POLY][NUM_BANK][NUM_ROW];

    logic                    fill_page;                    // host side page
    coef_t                   rd_row [NUM_POLY][NUM_BANK];   // full row tap
    logic [LOG_NUM_BANK-1:0] bank_q;                       // lane select for the tap

    // fill page is always the other one
    assign fill_page = ~rd.page;

    //////////////////////////////////////////////////////////////////////
    // host write
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin : host_wr
        for (int p = 0; p < NUM_POLY; p++) begin
            for (int b = 0; b < NUM_BANK; b++) begin
                // per-lane enable, masked lanes keep old value
                if (i_axi_we[p*NUM_BANK + b]) begin
                    mem[fill_page][p][b][i_axi_wraddr] <= i_axi_data[b];
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // compute read
    //////////////////////////////////////////////////////////////////////
    // whole row of every bank comes out, bank picked afterwards
    always_ff @(posedge clk) begin : row_rd
        if (rd.rd_en) begin
            bank_q <= rd.rd_addr.loc.bank;   // hold select with the data
            for (int p = 0; p < NUM_POLY; p++) begin
                for (int b = 0; b < NUM_BANK; b++) begin
                    rd_row[p][b] <= mem[rd.page][p][b][rd.rd_addr.loc.row];
                end
            end
        end
    end

    // bank mux after the row tap
    always_comb begin : bank_sel
        for (int p = 0; p < NUM_POLY; p++) begin
            rd.rd_data[p] = rd_row[p][bank_q];   // same bank for all polys
        end
    end

endmodule

`default_nettype wire

// ==== common/dp_rd_if.sv ====
// compute-side read path between control, ping-pong buffer and madd lanes
// control issues index reads, buffer answers one cycle later
`default_nettype none

interface dp_rd_if
    import dp_pkg::*;
();

    // all signals live in the clk domain of dp_top
    logic       page;       // compute page select
    logic       rd_en;      // one index issued this cycle
    coef_addr_u rd_addr;    // issued coefficient index
    coef_vec_t  rd_data;    // one coef per poly, cycle after rd_en

    // pass sequencer side
    modport ctrl (
        output page,
        output rd_en,
        output rd_addr
    );

    // banked storage side
    modport store (
        input  page,
        input  rd_en,
        input  rd_addr,
        output rd_data
    );

    // add lanes only watch the read stream
    modport lane (
        input rd_en,
        input rd_addr,
        input rd_data
    );

endinterface

`default_nettype wire

// ==== common/dp_pkg.sv ====
// shared widths, modulus and coefficient types for the dot-product datapath
// imported by every RTL block and by the testbench models
`default_nettype none

package dp_pkg;

    //////////////////////////////////////////////////////////////////////
    // sizes
    //////////////////////////////////////////////////////////////////////
    localparam int COE_WIDTH       = 39;                  // one coefficient
    localparam int LOG_NUM_BANK    = 3;                   // bank select width
    localparam int NUM_BANK        = 1 << LOG_NUM_BANK;   // 8 banks per poly
    localparam int ROW_ADDR_W      = 4;                   // rows per bank, kept short
    localparam int NUM_POLY        = 3;                   // polys in the vector
    localparam int COEF_ADDR_W     = ROW_ADDR_W + LOG_NUM_BANK;
    localparam int COEFS_PER_POLY  = NUM_BANK * (1 << ROW_ADDR_W);  // 128
    localparam int PSUM_RD_LATENCY = 1;                   // upstream psum memory read

    // coefficient types
    typedef logic [COE_WIDTH-1:0] coef_t;
    typedef coef_t [NUM_POLY-1:0] coef_vec_t;   // one coef per poly
    typedef coef_t [NUM_BANK-1:0] bank_row_t;   // one row across all banks

    // every stored value sits below this
    localparam coef_t DP_MODULUS = 39'd274877890561;

    // coefficient address, seen either flat or as row/bank
    // idx = row * NUM_BANK + bank, so the bank is the low field
    typedef union packed {
        logic [COEF_ADDR_W-1:0] idx;        // flat coefficient index
        struct packed {
            logic [ROW_ADDR_W-1:0]   row;   // upper bits
            logic [LOG_NUM_BANK-1:0] bank;  // lower bits
        } loc;
    } coef_addr_u;

endpackage

`default_nettype wire
